//--- verilog/alut_pkg.sv
//--------------------
// shared types and register map of the alut
// offsets are byte addresses on a 7-bit apb bus, word aligned
// table depth default lives here, top level may override it
//--------------------
package alut_pkg;

   localparam int alut_depth_dflt = 8;    // table entries, 2 or more

   typedef logic [47:0] mac_t;            // station address
   typedef logic [1:0]  port_t;           // switch port number
   typedef logic [4:0]  dport_t;          // forwarding mask, bit 4 is the switch
   typedef logic [31:0] stamp_t;          // time and entry stamp
   typedef logic [6:0]  apb_addr_t;
   typedef logic [31:0] word_t;

   typedef struct packed {
      logic      psel;
      logic      penable;
      logic      pwrite;
      apb_addr_t paddr;
      word_t     pwdata;
   } apb_req_t;

   typedef struct packed {
      mac_t  d_addr;
      mac_t  s_addr;
      port_t s_port;
   } frm_info_t;                          // frame under check

   typedef struct packed {
      mac_t  addr;
      port_t port;
   } inv_rec_t;                           // one invalidated entry

   typedef struct packed {
      logic   valid;
      mac_t   addr;
      port_t  port;
      stamp_t stamp;
   } tbl_entry_t;

   typedef enum logic [1:0] {
      cmd_none  = 2'd0,
      cmd_check = 2'd1,
      cmd_age   = 2'd2                    // code 3 unused
   } cmd_t;

   // register map
   localparam apb_addr_t al_frm_d_addr_l   = 7'h00;
   localparam apb_addr_t al_frm_d_addr_u   = 7'h04;
   localparam apb_addr_t al_frm_s_addr_l   = 7'h08;
   localparam apb_addr_t al_frm_s_addr_u   = 7'h0c;
   localparam apb_addr_t al_s_port         = 7'h10;
   localparam apb_addr_t al_d_port         = 7'h14;   // read only
   localparam apb_addr_t al_mac_addr_l     = 7'h18;
   localparam apb_addr_t al_mac_addr_u     = 7'h1c;
   localparam apb_addr_t al_cur_time       = 7'h20;   // read only
   localparam apb_addr_t al_bb_age         = 7'h24;
   localparam apb_addr_t al_div_clk        = 7'h28;
   localparam apb_addr_t al_command        = 7'h2c;   // reads zero
   localparam apb_addr_t al_status         = 7'h30;
   localparam apb_addr_t al_lst_inv_addr_l = 7'h34;
   localparam apb_addr_t al_lst_inv_addr_u = 7'h38;
   localparam apb_addr_t al_lst_inv_port   = 7'h3c;

endpackage

//--- verilog/alut_timer.sv
//--------------------
// current time, one tick every div_clk+1 cycles
// wraps at 2^32
//--------------------
`timescale 1ns/100ps

module alut_timer
(
   input  logic             pclk10,
   input  logic             n_p_reset10,
   input  logic [7:0]       div_clk,
   output alut_pkg::stamp_t curr_time
);
   logic [7:0] presc;       // prescale count

   always_ff @(posedge pclk10 or negedge n_p_reset10)
   begin
      if (!n_p_reset10)
      begin
         presc     <= '0;
         curr_time <= '0;
      end
      else if (presc >= div_clk)   // also catches a lowered divider
      begin
         presc     <= '0;
         curr_time <= curr_time + 1'b1;
      end
      else
         presc <= presc + 1'b1;
   end

endmodule

//--- verilog/alut_table.sv
//--------------------
// lookup table, parallel match on query
// write port has priority over invalidation
// victim is lowest free entry, round robin once full
//--------------------
`timescale 1ns/100ps

module alut_table #(
   parameter int alut_depth = alut_pkg::alut_depth_dflt
) (
   input  logic                          pclk10,
   input  logic                          n_p_reset10,
   input  alut_pkg::mac_t                query,
   output logic                          hit,
   output logic [$clog2(alut_depth)-1:0] hit_idx,
   output logic [$clog2(alut_depth)-1:0] victim_idx,
   input  logic                          wr_en,
   input  logic [$clog2(alut_depth)-1:0] wr_idx,
   input  alut_pkg::tbl_entry_t          wr_entry,
   input  logic [$clog2(alut_depth)-1:0] rd_idx,
   output alut_pkg::tbl_entry_t          rd_entry,
   input  logic                          inv_en,
   input  logic [$clog2(alut_depth)-1:0] inv_idx
);
   import alut_pkg::*;

   localparam int iw = $clog2(alut_depth);

   tbl_entry_t            mem [alut_depth];   // payload, valid kept apart
   logic [alut_depth-1:0] valid;
   logic [iw-1:0]         rr_ptr;             // replacement when full
   logic                  full;

   assign full     = &valid;
   assign rd_entry = tbl_entry_t'{valid[rd_idx], mem[rd_idx].addr,
                                  mem[rd_idx].port, mem[rd_idx].stamp};

   // lowest match and lowest free slot
   always_comb
   begin
      hit        = 1'b0;
      hit_idx    = '0;
      victim_idx = rr_ptr;
      for (int i = alut_depth - 1; i >= 0; i--)
      begin
         if (valid[i] && mem[i].addr == query)
         begin
            hit     = 1'b1;
            hit_idx = iw'(i);
         end
         if (!valid[i])
            victim_idx = iw'(i);
      end
   end

   always_ff @(posedge pclk10)
   begin
      if (wr_en)
         mem[wr_idx] <= wr_entry;
   end

   always_ff @(posedge pclk10 or negedge n_p_reset10)
   begin
      if (!n_p_reset10)
      begin
         valid  <= '0;
         rr_ptr <= '0;
      end
      else if (wr_en)
      begin
         valid[wr_idx] <= wr_entry.valid;
         if (full)
            rr_ptr <= (rr_ptr == iw'(alut_depth - 1)) ? '0 : rr_ptr + 1'b1;
      end
      else if (inv_en)
         valid[inv_idx] <= 1'b0;              // aged out
   end

   // the two checkers never run together
   a_no_wr_inv : assert property (@(posedge pclk10) disable iff (!n_p_reset10)
      !(wr_en && inv_en));

endmodule

//--- verilog/alut_addr_checker.sv
//--------------------
// one frame per cmd_check, two busy cycles
// search looks up d_addr, learn writes s_addr and its port
// reused stays set until a status read clears it
//--------------------
`timescale 1ns/100ps

module alut_addr_checker #(
   parameter int alut_depth = alut_pkg::alut_depth_dflt
) (
   input  logic                          pclk10,
   input  logic                          n_p_reset10,
   input  alut_pkg::cmd_t                command,
   input  alut_pkg::frm_info_t           frm,
   input  alut_pkg::mac_t                mac_addr,
   input  alut_pkg::stamp_t              curr_time,
   input  logic                          clear_reused,
   output logic                          active,
   output alut_pkg::dport_t              d_port,
   output logic                          reused,
   output alut_pkg::inv_rec_t            nrm_inv,
   output alut_pkg::mac_t                query,
   input  logic                          hit,
   input  logic [$clog2(alut_depth)-1:0] hit_idx,
   input  logic [$clog2(alut_depth)-1:0] victim_idx,
   output logic [$clog2(alut_depth)-1:0] rd_idx,
   input  alut_pkg::tbl_entry_t          rd_entry,
   output logic                          wr_en,
   output logic [$clog2(alut_depth)-1:0] wr_idx,
   output alut_pkg::tbl_entry_t          wr_entry
);
   import alut_pkg::*;

   typedef enum logic [1:0] {st_idle, st_search, st_learn} state_t;

   state_t                        state;
   logic [$clog2(alut_depth)-1:0] tgt_idx;   // hit entry, else victim
   dport_t                        fwd;       // mask for the current frame

   assign active   = (state != st_idle);
   assign query    = (state == st_learn) ? frm.s_addr : frm.d_addr;
   assign tgt_idx  = hit ? hit_idx : victim_idx;
   assign rd_idx   = tgt_idx;
   assign wr_en    = (state == st_learn);
   assign wr_idx   = tgt_idx;                // refresh in place on a hit
   assign wr_entry = tbl_entry_t'{1'b1, frm.s_addr, frm.s_port, curr_time};

   // forwarding rule on the d_addr lookup
   always_comb
   begin
      if (frm.d_addr == mac_addr)
         fwd = 5'b10000;                                 // to the switch
      else if (hit && rd_entry.port != frm.s_port)
         fwd = dport_t'(1) << rd_entry.port;
      else if (hit)
         fwd = '0;                                       // same port, drop
      else
         fwd = 5'b01111 & ~(dport_t'(1) << frm.s_port);  // flood
   end

   always_ff @(posedge pclk10 or negedge n_p_reset10)
   begin
      if (!n_p_reset10)
      begin
         state   <= st_idle;
         d_port  <= '0;
         reused  <= 1'b0;
         nrm_inv <= '0;
      end
      else
      begin
         case (state)
            st_idle :
               if (command == cmd_check)
                  state <= st_search;
            st_search :
            begin
               d_port <= fwd;
               state  <= st_learn;
            end
            st_learn :
            begin
               state <= st_idle;
               if (!hit && rd_entry.valid)               // victim overwritten
               begin
                  reused  <= 1'b1;
                  nrm_inv <= inv_rec_t'{rd_entry.addr, rd_entry.port};
               end
            end
            default : state <= st_idle;
         endcase
         if (clear_reused)
            reused <= 1'b0;                              // only when idle
      end
   end

   // a check command that arrives while busy would be lost
   a_cmd_idle : assert property (@(posedge pclk10) disable iff (!n_p_reset10)
      (command == cmd_check) |-> (state == st_idle));

endmodule

//--- verilog/alut_age_checker.sv
//--------------------
// sweeps one table entry per cycle after cmd_age
// runs only while the address checker is idle
// cmd_inv holds the latest aged entry of the sweep
//--------------------
`timescale 1ns/100ps

module alut_age_checker #(
   parameter int alut_depth = alut_pkg::alut_depth_dflt
) (
   input  logic                          pclk10,
   input  logic                          n_p_reset10,
   input  alut_pkg::cmd_t                command,
   input  alut_pkg::stamp_t              curr_time,
   input  alut_pkg::stamp_t              bb_age,
   output logic                          inval_in_prog,
   output alut_pkg::inv_rec_t            cmd_inv,
   output logic [$clog2(alut_depth)-1:0] rd_idx,
   input  alut_pkg::tbl_entry_t          rd_entry,
   output logic                          inv_en,
   output logic [$clog2(alut_depth)-1:0] inv_idx
);
   import alut_pkg::*;

   localparam int iw = $clog2(alut_depth);

   typedef enum logic {ag_idle, ag_sweep} state_t;

   state_t          state;
   logic [iw-1:0]   idx;        // entry under test
   stamp_t          age;
   logic            aged;
   inv_rec_t        last_rec;   // last entry cleared

   assign inval_in_prog = (state == ag_sweep);
   assign rd_idx        = idx;
   assign inv_idx       = idx;
   assign age           = curr_time - rd_entry.stamp;   // wraps mod 2^32
   assign aged          = inval_in_prog & rd_entry.valid & (age > bb_age);
   assign inv_en        = aged;
   assign cmd_inv       = aged ? inv_rec_t'{rd_entry.addr, rd_entry.port} : last_rec;

   always_ff @(posedge pclk10 or negedge n_p_reset10)
   begin
      if (!n_p_reset10)
      begin
         state    <= ag_idle;
         idx      <= '0;
         last_rec <= '0;
      end
      else if (state == ag_idle)
      begin
         idx <= '0;
         if (command == cmd_age)
            state <= ag_sweep;
      end
      else
      begin
         if (aged)
            last_rec <= cmd_inv;
         if (idx == iw'(alut_depth - 1))
            state <= ag_idle;                    // whole table seen
         idx <= idx + 1'b1;
      end
   end

endmodule

//--- verilog/alut_reg_bank.sv
//--------------------
// apb register file, no pready and no pslverr
// reads sampled in the setup phase, prdata zero outside access phase
// command clears itself one cycle after the write
//--------------------
`timescale 1ns/100ps

module alut_reg_bank
(
   input  logic                pclk10,
   input  logic                n_p_reset10,
   input  alut_pkg::apb_req_t  apb,
   output alut_pkg::word_t     prdata,
   input  alut_pkg::stamp_t    curr_time,
   input  logic                active,
   input  logic                inval_in_prog,
   input  logic                reused,
   input  alut_pkg::dport_t    d_port,
   input  alut_pkg::inv_rec_t  nrm_inv,
   input  alut_pkg::inv_rec_t  cmd_inv,
   output alut_pkg::frm_info_t frm,
   output alut_pkg::mac_t      mac_addr,
   output alut_pkg::stamp_t    bb_age,
   output logic [7:0]          div_clk,
   output alut_pkg::cmd_t      command,
   output logic                clear_reused
);
   import alut_pkg::*;

   logic     rd_en;          // setup phase of a read
   logic     wr_en;          // access phase of a write
   inv_rec_t lst_inv;        // last invalidated entry

   assign rd_en = apb.psel & ~apb.penable & ~apb.pwrite;
   assign wr_en = apb.psel & apb.penable & apb.pwrite;

   // status read acknowledges reuse, only once the checker is idle
   assign clear_reused = rd_en & (apb.paddr == al_status) & ~active;

   // --------------------
   // writable registers
   always_ff @(posedge pclk10 or negedge n_p_reset10)
   begin
      if (!n_p_reset10)
      begin
         frm      <= '0;
         mac_addr <= '0;
         bb_age   <= '1;     // nothing ages until programmed
         div_clk  <= '0;
      end
      else if (wr_en)
      begin
         case (apb.paddr)
            al_frm_d_addr_l : frm.d_addr[31:0]  <= apb.pwdata;
            al_frm_d_addr_u : frm.d_addr[47:32] <= apb.pwdata[15:0];
            al_frm_s_addr_l : frm.s_addr[31:0]  <= apb.pwdata;
            al_frm_s_addr_u : frm.s_addr[47:32] <= apb.pwdata[15:0];
            al_s_port       : frm.s_port        <= apb.pwdata[1:0];
            al_mac_addr_l   : mac_addr[31:0]    <= apb.pwdata;
            al_mac_addr_u   : mac_addr[47:32]   <= apb.pwdata[15:0];
            al_bb_age       : bb_age            <= apb.pwdata;
            al_div_clk      : div_clk           <= apb.pwdata[7:0];
            default         : ;                 // unmapped or read only
         endcase
      end
   end

   // command, one cycle wide, blocked while the other engine runs
   always_ff @(posedge pclk10 or negedge n_p_reset10)
   begin
      if (!n_p_reset10)
         command <= cmd_none;
      else if (command != cmd_none)
         command <= cmd_none;                   // self clear
      else if (wr_en && apb.paddr == al_command)
      begin
         case (apb.pwdata[1:0])
            2'd1    : command <= inval_in_prog ? cmd_none : cmd_check;
            2'd2    : command <= active ? cmd_none : cmd_age;
            default : command <= cmd_none;      // code 3 dropped
         endcase
      end
   end

   // last invalidated record, learning overwrite wins over aging
   always_ff @(posedge pclk10 or negedge n_p_reset10)
   begin
      if (!n_p_reset10)
         lst_inv <= '0;
      else if (reused)
         lst_inv <= nrm_inv;
      else if (inval_in_prog)
         lst_inv <= cmd_inv;
   end

   // --------------------
   // registered read mux
   always_ff @(posedge pclk10 or negedge n_p_reset10)
   begin
      if (!n_p_reset10)
         prdata <= '0;
      else if (rd_en)
      begin
         case (apb.paddr)
            al_frm_d_addr_l   : prdata <= frm.d_addr[31:0];
            al_frm_d_addr_u   : prdata <= word_t'(frm.d_addr[47:32]);
            al_frm_s_addr_l   : prdata <= frm.s_addr[31:0];
            al_frm_s_addr_u   : prdata <= word_t'(frm.s_addr[47:32]);
            al_s_port         : prdata <= word_t'(frm.s_port);
            al_d_port         : prdata <= word_t'(d_port);
            al_mac_addr_l     : prdata <= mac_addr[31:0];
            al_mac_addr_u     : prdata <= word_t'(mac_addr[47:32]);
            al_cur_time       : prdata <= curr_time;
            al_bb_age         : prdata <= bb_age;
            al_div_clk        : prdata <= word_t'(div_clk);
            al_status         : prdata <= word_t'({reused, inval_in_prog, active});
            al_lst_inv_addr_l : prdata <= lst_inv.addr[31:0];
            al_lst_inv_addr_u : prdata <= word_t'(lst_inv.addr[47:32]);
            al_lst_inv_port   : prdata <= word_t'(lst_inv.port);
            default           : prdata <= '0;
         endcase
      end
      else
         prdata <= '0;       // only valid in access phase
   end

   // --------------------
   // checks
   a_no_rd_wr : assert property (@(posedge pclk10) disable iff (!n_p_reset10)
      !(rd_en && wr_en));

   // written code shows up next cycle unless blocked by the busy engine
   a_cmd_wr : assert property (@(posedge pclk10) disable iff (!n_p_reset10)
      (wr_en && apb.paddr == al_command) |=>
      (command == ((($past(apb.pwdata[1:0]) == 2'd1) && !$past(inval_in_prog)) ||
                   (($past(apb.pwdata[1:0]) == 2'd2) && !$past(active)) ?
                   $past(apb.pwdata[1:0]) : 2'd0)));

endmodule

//--- verilog/alut.sv
//--------------------
// alut top, apb slave with no back pressure
// table read port goes to the address checker while it is active
//--------------------
`timescale 1ns/100ps

module alut #(
   parameter int alut_depth = alut_pkg::alut_depth_dflt
) (
   input  logic               pclk10,
   input  logic               n_p_reset10,
   input  alut_pkg::apb_req_t apb,
   output alut_pkg::word_t    prdata
);
   import alut_pkg::*;

   localparam int iw = $clog2(alut_depth);

   frm_info_t     frm;
   mac_t          mac_addr;
   mac_t          query;
   stamp_t        bb_age;
   stamp_t        curr_time;
   logic [7:0]    div_clk;
   cmd_t          command;
   logic          active;
   logic          inval_in_prog;
   logic          reused;
   logic          clear_reused;
   dport_t        d_port;
   inv_rec_t      nrm_inv;
   inv_rec_t      cmd_inv;
   logic          hit;
   logic          wr_en;
   logic          inv_en;
   logic [iw-1:0] hit_idx;
   logic [iw-1:0] victim_idx;
   logic [iw-1:0] wr_idx;
   logic [iw-1:0] inv_idx;
   logic [iw-1:0] ac_rd_idx;       // address checker read
   logic [iw-1:0] ag_rd_idx;       // age checker read
   logic [iw-1:0] rd_idx;
   tbl_entry_t    wr_entry;
   tbl_entry_t    rd_entry;

   assign rd_idx = active ? ac_rd_idx : ag_rd_idx;

   alut_reg_bank u_reg_bank (
      .pclk10, .n_p_reset10, .apb, .prdata, .curr_time, .active, .inval_in_prog,
      .reused, .d_port, .nrm_inv, .cmd_inv, .frm, .mac_addr, .bb_age, .div_clk,
      .command, .clear_reused);

   alut_addr_checker #(.alut_depth(alut_depth)) u_addr_checker (
      .pclk10, .n_p_reset10, .command, .frm, .mac_addr, .curr_time, .clear_reused,
      .active, .d_port, .reused, .nrm_inv, .query, .hit, .hit_idx, .victim_idx,
      .rd_idx(ac_rd_idx), .rd_entry, .wr_en, .wr_idx, .wr_entry);

   alut_age_checker #(.alut_depth(alut_depth)) u_age_checker (
      .pclk10, .n_p_reset10, .command, .curr_time, .bb_age, .inval_in_prog,
      .cmd_inv, .rd_idx(ag_rd_idx), .rd_entry, .inv_en, .inv_idx);

   alut_table #(.alut_depth(alut_depth)) u_table (
      .pclk10, .n_p_reset10, .query, .hit, .hit_idx, .victim_idx, .wr_en, .wr_idx,
      .wr_entry, .rd_idx, .rd_entry, .inv_en, .inv_idx);

   alut_timer u_timer (.pclk10, .n_p_reset10, .div_clk, .curr_time);

endmodule

//--- test/alut_tb.sv
//--------------------
// alut testbench, depth 8, fixed seed
// tasks expect to start 1 ns after a rising edge
// stops at the first mismatch
//--------------------
`timescale 1ns/100ps

module alut_tb;
   import alut_pkg::*;

   localparam int depth    = 8;
   localparam int pool_sz  = 12;           // more than depth, forces replacement
   localparam int poll_max = 64;

   logic       pclk10;
   logic       n_p_reset10;
   apb_req_t   apb;
   word_t      prdata;

   integer     seed = 4946;
   mac_t       pool [pool_sz];
   mac_t       sw_mac;                     // switch own address
   logic       m_valid [depth];            // reference table
   mac_t       m_addr [depth];
   port_t      m_port [depth];
   int         m_rr;                       // round robin when full
   inv_rec_t   m_lst;                      // expected last invalidated
   inv_rec_t   m_age_last;                 // last aged entry seen by sweeps
   int         n_reuse;
   logic [3:0] seen;                       // switch, hit, same port, miss

   alut #(.alut_depth(depth)) u_alut (.pclk10, .n_p_reset10, .apb, .prdata);

   initial
   begin
      pclk10 = 1'b0;
      forever #4 pclk10 = ~pclk10;         // 8 ns period
   end

   task automatic abort_run();
      $display("TEST RESULT: FAIL");
      $fatal(1, "simulation stopped at first error");
   endtask

   task automatic check_word(input string name, input word_t got, input word_t exp);
      if (got !== exp)
      begin
         $display("error %s got %h expected %h", name, got, exp);
         abort_run();
      end
   endtask

   task automatic check_dport(input string name, input dport_t got, input dport_t exp);
      if (got !== exp)
      begin
         $display("error %s got %h expected %h", name, got, exp);
         abort_run();
      end
   endtask

   task automatic check_mac(input string name, input mac_t got, input mac_t exp);
      if (got !== exp)
      begin
         $display("error %s got %h expected %h", name, got, exp);
         abort_run();
      end
   endtask

   task automatic check_port(input string name, input port_t got, input port_t exp);
      if (got !== exp)
      begin
         $display("error %s got %h expected %h", name, got, exp);
         abort_run();
      end
   endtask

   // --------------------
   // apb transfers
   task automatic apb_write(input apb_addr_t a, input word_t d);
      apb.psel    = 1'b1;                  // setup
      apb.penable = 1'b0;
      apb.pwrite  = 1'b1;
      apb.paddr   = a;
      apb.pwdata  = d;
      @(posedge pclk10);
      #1 apb.penable = 1'b1;               // access, write lands at next edge
      @(posedge pclk10);
      #1 apb = '0;
   endtask

   task automatic apb_read(input apb_addr_t a, output word_t d);
      @(posedge pclk10);                   // one idle cycle first
      #1;
      apb.psel    = 1'b1;
      apb.penable = 1'b0;
      apb.pwrite  = 1'b0;
      apb.paddr   = a;
      @(posedge pclk10);                   // setup edge samples the data
      #1 apb.penable = 1'b1;
      d = prdata;
      @(posedge pclk10);
      #1 apb = '0;
   endtask

   task automatic wait_idle(output word_t st);
      int n;
      n = 0;
      apb_read(al_status, st);
      while (st[1:0] != 2'b00)
      begin
         n++;
         if (n > poll_max)
         begin
            $display("status poll timed out, engine still busy");
            abort_run();
         end
         apb_read(al_status, st);
      end
   endtask

   // --------------------
   // reference model
   function automatic int find_addr(input mac_t a);
      for (int i = 0; i < depth; i++)
         if (m_valid[i] && m_addr[i] == a)
            return i;
      return -1;
   endfunction

   function automatic apb_addr_t rw_reg(input int k);
      case (k)
         0       : return al_frm_d_addr_l;
         1       : return al_frm_d_addr_u;
         2       : return al_frm_s_addr_l;
         3       : return al_frm_s_addr_u;
         4       : return al_s_port;
         5       : return al_mac_addr_l;
         6       : return al_mac_addr_u;
         7       : return al_bb_age;
         default : return al_div_clk;
      endcase
   endfunction

   function automatic word_t rw_mask(input apb_addr_t a);
      case (a)
         al_frm_d_addr_u, al_frm_s_addr_u, al_mac_addr_u : return 32'h0000_ffff;
         al_s_port                                       : return 32'h0000_0003;
         al_div_clk                                      : return 32'h0000_00ff;
         default                                         : return 32'hffff_ffff;
      endcase
   endfunction

   // forwarding on d, then learning of s
   task automatic model_frame(input mac_t d, input mac_t s, input port_t sp,
                              output dport_t fwd, output logic rsd);
      int   h;
      int   v;
      logic full;
      h   = find_addr(d);
      fwd = '0;
      if (d == sw_mac)
      begin
         fwd[4]  = 1'b1;
         seen[0] = 1'b1;
      end
      else if (h >= 0 && m_port[h] != sp)
      begin
         for (int p = 0; p < 4; p++)
            fwd[p] = (p == int'(m_port[h]));   // known station elsewhere
         seen[1] = 1'b1;
      end
      else if (h >= 0)
         seen[2] = 1'b1;                   // same port, dropped
      else
      begin
         for (int p = 0; p < 4; p++)
            fwd[p] = (p != int'(sp));      // flood
         seen[3] = 1'b1;
      end
      h = find_addr(s);
      v = -1;
      for (int i = 0; i < depth; i++)
         if (!m_valid[i] && v < 0)
            v = i;                         // lowest free slot wins
      full = (v < 0);
      if (full)
         v = m_rr;
      if (h >= 0)
         v = h;                            // refresh in place
      rsd = (h < 0) && m_valid[v];
      if (rsd)
      begin
         m_lst.addr = m_addr[v];
         m_lst.port = m_port[v];
         n_reuse++;
      end
      if (full)
         m_rr = (m_rr + 1) % depth;
      m_valid[v] = 1'b1;
      m_addr[v]  = s;
      m_port[v]  = sp;
   endtask

   task automatic check_last_inv();
      word_t lo;
      word_t hi;
      word_t p;
      apb_read(al_lst_inv_addr_l, lo);
      apb_read(al_lst_inv_addr_u, hi);
      apb_read(al_lst_inv_port, p);
      check_mac("lst_inv_addr", {hi[15:0], lo}, m_lst.addr);
      check_port("lst_inv_port", port_t'(p), m_lst.port);
   endtask

   task automatic run_frame(input mac_t d, input mac_t s, input port_t sp);
      word_t  w;
      dport_t fwd;
      logic   rsd;
      apb_write(al_frm_d_addr_l, d[31:0]);
      apb_write(al_frm_d_addr_u, word_t'(d[47:32]));
      apb_write(al_frm_s_addr_l, s[31:0]);
      apb_write(al_frm_s_addr_u, word_t'(s[47:32]));
      apb_write(al_s_port, word_t'(sp));
      model_frame(d, s, sp, fwd, rsd);
      apb_write(al_command, word_t'(cmd_check));
      wait_idle(w);                        // idle read also clears reuse
      check_word("status", w, word_t'({rsd, 2'b00}));
      apb_read(al_d_port, w);
      check_dport("d_port", dport_t'(w), fwd);
      check_last_inv();
      if (rsd)
      begin
         apb_read(al_status, w);
         check_word("status", w, 32'h0);   // bit 2 gone after read
      end
   endtask

   task automatic run_sweep(input logic all_aged);
      word_t w;
      apb_write(al_command, word_t'(cmd_age));
      wait_idle(w);
      check_word("status", w, 32'h0);
      if (all_aged)
         for (int i = 0; i < depth; i++)
            if (m_valid[i])
            begin
               m_age_last.addr = m_addr[i];   // highest index ends up last
               m_age_last.port = m_port[i];
               m_valid[i]      = 1'b0;
            end
      m_lst = m_age_last;                  // record reloads every sweep cycle
      check_last_inv();
   endtask

   // --------------------
   // main sequence
   initial
   begin
      word_t     w;
      word_t     t0;
      word_t     d;
      apb_addr_t a;
      int        dv;
      int        dt;
      int        exp_dt;

      n_p_reset10 = 1'b0;
      apb         = '0;
      for (int i = 0; i < depth; i++)
         m_valid[i] = 1'b0;
      m_rr       = 0;
      m_lst      = '0;
      m_age_last = '0;
      n_reuse    = 0;
      seen       = '0;
      for (int i = 0; i < pool_sz; i++)
         pool[i] = {8'h02, 8'(i), $random(seed)};   // distinct by index
      sw_mac = pool[pool_sz - 1];
      repeat (4) @(posedge pclk10);
      #1 n_p_reset10 = 1'b1;

      apb_read(al_bb_age, w);
      check_word("bb_age", w, 32'hffff_ffff);
      apb_read(al_status, w);
      check_word("status", w, 32'h0);
      apb_read(al_d_port, w);
      check_word("d_port", w, 32'h0);

      // register readback with masking
      repeat (40)
      begin
         a = rw_reg(int'({$random(seed)} % 9));
         d = $random(seed);
         apb_write(a, d);
         apb_read(a, w);
         check_word($sformatf("reg_%h", a), w, d & rw_mask(a));
      end
      repeat (10)
      begin
         a = apb_addr_t'(7'h40 | ({$random(seed)} & 7'h3f));   // above the map
         apb_write(a, $random(seed));
         apb_read(a, w);
         check_word($sformatf("reg_%h", a), w, 32'h0);
      end
      apb_write(al_command, 32'h3);        // unused code, no engine starts
      apb_read(al_command, w);
      check_word("command", w, 32'h0);

      apb_write(al_mac_addr_l, sw_mac[31:0]);
      apb_write(al_mac_addr_u, word_t'(sw_mac[47:32]));
      apb_write(al_bb_age, 32'hffff_ffff);
      apb_write(al_div_clk, 32'h0);

      // forwarding, learning, replacement
      repeat (80)
         run_frame(pool[{$random(seed)} % pool_sz], pool[{$random(seed)} % pool_sz],
                   port_t'($random(seed)));
      if (seen != 4'hf)
      begin
         $display("not every forwarding case was exercised");
         abort_run();
      end
      if (n_reuse == 0)
      begin
         $display("no table entry was ever replaced");
         abort_run();
      end

      // timer against a counted gap
      dv = 1 + int'({$random(seed)} % 7);
      apb_write(al_div_clk, word_t'(dv));
      apb_read(al_cur_time, t0);
      repeat (200) @(posedge pclk10);
      apb_read(al_cur_time, w);
      dt     = int'(w - t0);
      exp_dt = 203 / (dv + 1);             // 200 idle plus 3 transfer cycles
      if (dt < exp_dt - 1 || dt > exp_dt + 1)
      begin
         $display("error cur_time delta got %h expected %h", dt, exp_dt);
         abort_run();
      end

      // sweep that ages nothing
      apb_write(al_bb_age, 32'hffff_ffff);
      run_sweep(1'b0);
      repeat (12)
         run_frame(pool[{$random(seed)} % (pool_sz - 1)],
                   pool[{$random(seed)} % (pool_sz - 1)], port_t'($random(seed)));

      // sweep that ages everything
      apb_write(al_div_clk, 32'h0);
      apb_write(al_bb_age, 32'h0);
      run_sweep(1'b1);
      for (int i = 0; i < pool_sz - 1; i++)
         run_frame(pool[i], sw_mac, port_t'($random(seed)));   // all miss

      $display("TEST RESULT: PASS");
      $finish;
   end

endmodule

//--- flist.f
verilog/alut_pkg.sv
verilog/alut_timer.sv
verilog/alut_table.sv
verilog/alut_addr_checker.sv
verilog/alut_age_checker.sv
verilog/alut_reg_bank.sv
verilog/alut.sv
test/alut_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the alut testbench, exit status is the verdict
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module alut_tb -f flist.f -o alut_sim &&
./obj_dir/alut_sim ||
{ echo "alut simulation did not complete cleanly"; exit 1; }
